// File: rtl/echo_rx_pkg.sv
`default_nettype none

package echo_rx_pkg;

	// Template-compared header length in bytes.
	localparam int unsigned header_bytes = 40;

	// Ping identifier, high byte first.
	localparam int unsigned id_hi_pos = 40;
	localparam int unsigned id_lo_pos = 41;

	// Shortest frame that carries the full identifier.
	localparam int unsigned min_frame_bytes = 42;

	// IP header and ICMP checksums, never compared.
	localparam int unsigned cksum_ip_hi = 24;
	localparam int unsigned cksum_ip_lo = 25;
	localparam int unsigned cksum_icmp_hi = 36;
	localparam int unsigned cksum_icmp_lo = 37;

	// Byte position counter, saturates at 63.
	localparam int unsigned pos_width = 6;

	typedef enum logic [7:0] {
		ICMP_ECHO_REPLY = 8'd0,
		ICMP_ECHO_REQUEST = 8'd8
	} icmp_type_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_ACTIVE,
		RX_TAIL
	} parse_state_t;

endpackage

`default_nettype wire

// File: rtl/echo_frame_parser.sv
`default_nettype none
`timescale 1ns/1ps

module echo_frame_parser (
	input wire logic clk_rx,
	input wire logic rst_rx,
	input wire logic [7:0] rx_data,
	input wire logic rx_last,
	input wire logic rx_valid,
	output logic [echo_rx_pkg::pos_width-1:0] byte_pos,
	output logic frame_start,
	output logic frame_done,
	output logic [15:0] frame_id_rx,
	output logic length_ok
);
	echo_rx_pkg::parse_state_t state;

	// First byte of a frame arrives while no frame is open.
	assign frame_start = rx_valid && (state == echo_rx_pkg::RX_IDLE);

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			state <= echo_rx_pkg::RX_IDLE;
			byte_pos <= '0;
			frame_done <= 1'b0;
			length_ok <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (!rx_valid) begin
				// Gap abort, frame is dropped silently.
				state <= echo_rx_pkg::RX_IDLE;
				byte_pos <= '0;
			end else if (rx_last) begin
				state <= echo_rx_pkg::RX_IDLE;
				byte_pos <= '0;
				frame_done <= 1'b1;
				length_ok <= (byte_pos >= echo_rx_pkg::min_frame_bytes - 1);
			end else begin
				if (byte_pos >= echo_rx_pkg::id_lo_pos)
					state <= echo_rx_pkg::RX_TAIL;
				else
					state <= echo_rx_pkg::RX_ACTIVE;
				if (byte_pos != '1)
					byte_pos <= byte_pos + 1'b1;
			end
		end
	end

	// Identifier bytes only exist before the tail.
	always_ff @(posedge clk_rx) begin
		if (rx_valid && state != echo_rx_pkg::RX_TAIL) begin
			if (byte_pos == echo_rx_pkg::id_hi_pos)
				frame_id_rx[15:8] <= rx_data;
			if (byte_pos == echo_rx_pkg::id_lo_pos)
				frame_id_rx[7:0] <= rx_data;
		end
	end

	// A completion pulse always follows a sampled last byte.
	assert property (@(posedge clk_rx) disable iff (rst_rx)
		frame_done |-> $past(rx_valid && rx_last));

endmodule

`default_nettype wire

// File: rtl/echo_header_compare.sv
`default_nettype none
`timescale 1ns/1ps

module echo_header_compare #(
	parameter echo_rx_pkg::icmp_type_t ICMP_TYPE = echo_rx_pkg::ICMP_ECHO_REPLY
) (
	input wire logic clk_rx,
	input wire logic rst_rx,
	input wire logic [7:0] rx_data,
	input wire logic rx_skip,
	input wire logic rx_valid,
	input wire logic [echo_rx_pkg::pos_width-1:0] byte_pos,
	input wire logic frame_start,
	input wire logic [47:0] mac_dst,
	input wire logic [47:0] mac_src,
	input wire logic [31:0] ip_src,
	input wire logic [31:0] ip_dst,
	input wire logic [15:0] frame_id,
	input wire logic [15:0] log_id,
	output logic header_ok
);
	localparam int unsigned tmpl_bits = echo_rx_pkg::header_bytes * 8;

	logic [tmpl_bits-1:0] template_vec;
	logic [7:0] expected;
	logic in_header;
	logic is_cksum;
	logic compare_en;
	logic byte_ok;
	int unsigned sel;

	// Byte 0 sits in the top octet.
	assign template_vec = {
		mac_dst,
		mac_src,
		48'h0800_4500_001C,
		frame_id,
		48'h4000_4001_0000,
		ip_src,
		ip_dst,
		8'(ICMP_TYPE),
		24'h00_0000,
		log_id
	};

	assign in_header = (byte_pos < echo_rx_pkg::header_bytes);

	// Checksums change per frame.
	assign is_cksum = (byte_pos == echo_rx_pkg::cksum_ip_hi) ||
		(byte_pos == echo_rx_pkg::cksum_ip_lo) ||
		(byte_pos == echo_rx_pkg::cksum_icmp_hi) ||
		(byte_pos == echo_rx_pkg::cksum_icmp_lo);

	always_comb begin
		sel = 0;
		if (in_header)
			sel = echo_rx_pkg::header_bytes - 1 - int'(byte_pos);
		expected = template_vec[sel*8 +: 8];
	end

	// Bytes rewritten by the MAC carry rx_skip.
	assign compare_en = rx_valid && in_header && !is_cksum && !rx_skip;
	assign byte_ok = !compare_en || (rx_data == expected);

	// Sticky match flag, re-armed on the first byte.
	// Includes the last byte, so it lines up with frame_done.
	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			header_ok <= 1'b1;
		end else if (rx_valid) begin
			if (frame_start)
				header_ok <= byte_ok;
			else
				header_ok <= header_ok && byte_ok;
		end
	end

endmodule

`default_nettype wire

// File: rtl/echo_report_queue.sv
`default_nettype none
`timescale 1ns/1ps

module echo_report_queue #(
	parameter int REPORT_DEPTH = 4
) (
	input wire logic clk_rx,
	input wire logic rst_rx,
	input wire logic frame_done,
	input wire logic header_ok,
	input wire logic length_ok,
	input wire logic [15:0] frame_id_rx,
	input wire logic report_ready,
	output logic [15:0] report_id,
	output logic report_valid,
	output logic [15:0] drop_count
);
	localparam int ptr_w = (REPORT_DEPTH > 1) ? $clog2(REPORT_DEPTH) : 1;
	localparam int cnt_w = $clog2(REPORT_DEPTH + 1);

	logic [15:0] mem [REPORT_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic accept;
	logic full;
	logic push;
	logic pop;

	assign accept = frame_done && header_ok && length_ok;
	assign full = (count == cnt_w'(REPORT_DEPTH));
	assign push = accept && !full;
	assign pop = report_valid && report_ready;

	assign report_valid = (count != '0);
	assign report_id = mem[rd_ptr];

	always_ff @(posedge clk_rx) begin
		if (push)
			mem[wr_ptr] <= frame_id_rx;
	end

	always_ff @(posedge clk_rx) begin
		if (rst_rx) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			drop_count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ptr_w'(REPORT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ptr_w'(REPORT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
			// Counter sticks at its top value.
			if (accept && full && drop_count != 16'hFFFF)
				drop_count <= drop_count + 1'b1;
		end
	end

	// Waiting head entry must not change under it.
	assert property (@(posedge clk_rx) disable iff (rst_rx)
		report_valid && !report_ready |=> report_valid && $stable(report_id));

	assert property (@(posedge clk_rx) disable iff (rst_rx)
		count <= cnt_w'(REPORT_DEPTH));

endmodule

`default_nettype wire

// File: rtl/echo_rx_top.sv
`default_nettype none
`timescale 1ns/1ps

module echo_rx_top #(
	parameter echo_rx_pkg::icmp_type_t ICMP_TYPE = echo_rx_pkg::ICMP_ECHO_REPLY,
	parameter int REPORT_DEPTH = 4
) (
	input wire logic clk_rx,
	input wire logic rst_rx,
	input wire logic [7:0] rx_data,
	input wire logic rx_skip,
	input wire logic rx_last,
	input wire logic rx_valid,
	input wire logic [47:0] mac_dst,
	input wire logic [47:0] mac_src,
	input wire logic [31:0] ip_src,
	input wire logic [31:0] ip_dst,
	input wire logic [15:0] frame_id,
	input wire logic [15:0] log_id,
	input wire logic report_ready,
	output logic [15:0] report_id,
	output logic report_valid,
	output logic [15:0] drop_count
);
	logic [echo_rx_pkg::pos_width-1:0] byte_pos;
	logic frame_start;
	logic frame_done;
	logic [15:0] frame_id_rx;
	logic length_ok;
	logic header_ok;

	echo_frame_parser u_parser (
		.clk_rx(clk_rx),
		.rst_rx(rst_rx),
		.rx_data(rx_data),
		.rx_last(rx_last),
		.rx_valid(rx_valid),
		.byte_pos(byte_pos),
		.frame_start(frame_start),
		.frame_done(frame_done),
		.frame_id_rx(frame_id_rx),
		.length_ok(length_ok)
	);

	echo_header_compare #(
		.ICMP_TYPE(ICMP_TYPE)
	) u_compare (
		.clk_rx(clk_rx),
		.rst_rx(rst_rx),
		.rx_data(rx_data),
		.rx_skip(rx_skip),
		.rx_valid(rx_valid),
		.byte_pos(byte_pos),
		.frame_start(frame_start),
		.mac_dst(mac_dst),
		.mac_src(mac_src),
		.ip_src(ip_src),
		.ip_dst(ip_dst),
		.frame_id(frame_id),
		.log_id(log_id),
		.header_ok(header_ok)
	);

	echo_report_queue #(
		.REPORT_DEPTH(REPORT_DEPTH)
	) u_queue (
		.clk_rx(clk_rx),
		.rst_rx(rst_rx),
		.frame_done(frame_done),
		.header_ok(header_ok),
		.length_ok(length_ok),
		.frame_id_rx(frame_id_rx),
		.report_ready(report_ready),
		.report_id(report_id),
		.report_valid(report_valid),
		.drop_count(drop_count)
	);

endmodule

`default_nettype wire

// File: tb/echo_rx_checker.sv
`default_nettype none
`timescale 1ns/1ps

module echo_rx_checker (
	input wire logic clk_rx,
	input wire logic rst_rx,
	input wire logic [15:0] report_id,
	input wire logic report_valid,
	input wire logic report_ready,
	input wire logic [15:0] drop_count
);
	logic [8*16-1:0] exp_name [$];
	logic [15:0] exp_id [$];
	logic [15:0] exp_drops;
	logic waiting;
	logic [15:0] held_id;
	int tests;
	int errors;

	initial begin
		exp_drops = '0;
		waiting = 1'b0;
		held_id = '0;
		tests = 0;
		errors = 0;
	end

	task automatic expect_report(input logic [8*16-1:0] name, input logic [15:0] id);
		exp_name.push_back(name);
		exp_id.push_back(id);
	endtask

	task automatic expect_drop();
		exp_drops = exp_drops + 1'b1;
	endtask

	function automatic int pending();
		return exp_id.size();
	endfunction

	// Frames with no report finish here.
	task automatic settle_check(input logic [8*16-1:0] name, input logic reported);
		if (drop_count != exp_drops) begin
			$display("mismatch: %0s drop_count expected %0d actual %0d", name, exp_drops,
				drop_count);
			errors++;
		end
		if (!reported) begin
			tests++;
			$display("done: %0s (no report expected)", name);
		end
	endtask

	// Sampled mid-cycle, away from the driving edge.
	always @(negedge clk_rx) begin
		if (rst_rx) begin
			waiting = 1'b0;
		end else begin
			if (waiting && (!report_valid || report_id != held_id)) begin
				$display("report %h was withdrawn or changed before it was accepted", held_id);
				errors++;
			end
			if (report_valid && report_ready) begin
				if (exp_id.size() == 0) begin
					$display("unexpected report with id %h", report_id);
					errors++;
				end else begin
					tests++;
					if (report_id != exp_id[0]) begin
						$display("mismatch: %0s report_id expected %h actual %h", exp_name[0],
							exp_id[0], report_id);
						errors++;
					end else begin
						$display("pass: %0s reported id %h", exp_name[0], report_id);
					end
					exp_name.delete(0);
					exp_id.delete(0);
				end
			end
			waiting = report_valid && !report_ready;
			held_id = report_id;
		end
	end

endmodule

`default_nettype wire

// File: tb/echo_rx_tb.sv
`default_nettype none
`timescale 1ns/1ps

module echo_rx_tb;
	localparam int report_depth = 4;
	localparam int drain_limit = 4000;

	// Fixed EtherType and IP header bytes.
	localparam logic [47:0] eth_ip_bytes = 48'h08_00_45_00_00_1c;
	localparam logic [47:0] ip_flags_bytes = 48'h40_00_40_01_00_00;

	logic clk_rx;
	logic rst_rx;
	logic [7:0] rx_data;
	logic rx_skip;
	logic rx_last;
	logic rx_valid;
	logic [47:0] mac_dst;
	logic [47:0] mac_src;
	logic [31:0] ip_src;
	logic [31:0] ip_dst;
	logic [15:0] frame_id;
	logic [15:0] log_id;
	logic report_ready;
	logic [15:0] report_id;
	logic report_valid;
	logic [15:0] drop_count;
	logic hold_ready;
	logic aborted;
	logic [31:0] rng;

	echo_rx_top #(
		.ICMP_TYPE(echo_rx_pkg::ICMP_ECHO_REPLY),
		.REPORT_DEPTH(report_depth)
	) u_echo_rx_top (.*);

	echo_rx_checker u_checker (.*);

	initial begin
		clk_rx = 1'b0;
		forever #20 clk_rx = ~clk_rx;
	end

	function automatic logic [31:0] next_rand(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	// Byte p of an echo reply carrying ping identifier id.
	function automatic logic [7:0] frame_byte(input int p, input logic [15:0] id);
		logic [7:0] b;
		if (p < 6)
			b = mac_dst[8*(5-p) +: 8];
		else if (p < 12)
			b = mac_src[8*(11-p) +: 8];
		else if (p < 18)
			b = eth_ip_bytes[8*(17-p) +: 8];
		else if (p < 20)
			b = frame_id[8*(19-p) +: 8];
		else if (p < 26)
			b = ip_flags_bytes[8*(25-p) +: 8];
		else if (p < 30)
			b = ip_src[8*(29-p) +: 8];
		else if (p < 34)
			b = ip_dst[8*(33-p) +: 8];
		else if (p < 38)
			b = 8'h00;
		else if (p < 40)
			b = log_id[8*(39-p) +: 8];
		else if (p < 42)
			b = id[8*(41-p) +: 8];
		else
			b = 8'(p * 13) ^ id[7:0];
		return b;
	endfunction

	task automatic send_frame(input logic [15:0] id, input int len, input int bad,
		input int skip, input int gap);
		// A gap position ends the frame early with rx_valid low.
		for (int p = 0; p < len && p != gap; p++) begin
			rx_data = frame_byte(p, id) ^ ((p == bad) ? 8'h08 : 8'h00);
			rx_skip = (p == skip);
			rx_last = (p == len - 1);
			rx_valid = 1'b1;
			@(posedge clk_rx);
			#5;
		end
		rx_valid = 1'b0;
		rx_last = 1'b0;
		rx_skip = 1'b0;
		repeat (3) begin
			@(posedge clk_rx);
			#5;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((u_checker.pending() != 0 || report_valid) && n < drain_limit) begin
			@(posedge clk_rx);
			#5;
			n++;
		end
		if (u_checker.pending() != 0 || report_valid) begin
			$display("timeout: reports still outstanding after %0d cycles", drain_limit);
			aborted = 1'b1;
		end
	endtask

	initial begin
		report_ready = 1'b0;
		rng = 32'h0a64c629;
		forever begin
			@(posedge clk_rx);
			#5;
			rng = next_rand(rng);
			report_ready = !hold_ready && rng[4];
		end
	end

	initial begin
		logic [8*160-1:0] line;
		logic [8*16-1:0] kw;
		logic [8*16-1:0] name;
		logic [8*16-1:0] outcome;
		logic [15:0] id;
		int len;
		int bad;
		int skip;
		int gap;
		int hold_val;
		int fd;
		int rc;
		rst_rx = 1'b1;
		rx_data = '0;
		rx_skip = 1'b0;
		rx_last = 1'b0;
		rx_valid = 1'b0;
		mac_dst = '0;
		mac_src = '0;
		ip_src = '0;
		ip_dst = '0;
		frame_id = '0;
		log_id = '0;
		hold_ready = 1'b0;
		aborted = 1'b0;
		repeat (2) @(posedge clk_rx);
		#5;
		rst_rx = 1'b0;
		fd = $fopen("tb/echo_rx_stimulus.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			aborted = 1'b1;
		end
		while (!aborted && !$feof(fd)) begin
			line = '0;
			kw = '0;
			rc = $fgets(line, fd);
			rc = $sscanf(line, "%s", kw);
			if (kw == "cfg") begin
				rc = $sscanf(line, "cfg %h %h %h %h %h %h", mac_dst, mac_src, ip_src,
					ip_dst, frame_id, log_id);
				if (rc != 6) begin
					$display("malformed configuration line in the stimulus file");
					aborted = 1'b1;
				end
			end else if (kw == "hold") begin
				rc = $sscanf(line, "hold %d", hold_val);
				// Start the burst from an empty queue.
				if (hold_val != 0)
					wait_drain();
				hold_ready = (hold_val != 0);
			end else if (kw == "frame") begin
				rc = $sscanf(line, "frame %s %h %d %d %d %d %s", name, id, len, bad, skip,
					gap, outcome);
				if (rc != 7) begin
					$display("malformed frame line in the stimulus file");
					aborted = 1'b1;
				end else begin
					if (outcome == "report")
						u_checker.expect_report(name, id);
					else if (outcome == "drop")
						u_checker.expect_drop();
					send_frame(id, len, bad, skip, gap);
					u_checker.settle_check(name, outcome == "report");
				end
			end
		end
		if (!aborted)
			wait_drain();
		$display("tests: %0d  errors: %0d", u_checker.tests, u_checker.errors);
		if (u_checker.errors == 0 && !aborted)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
rtl/echo_rx_pkg.sv
rtl/echo_frame_parser.sv
rtl/echo_header_compare.sv
rtl/echo_report_queue.sv
rtl/echo_rx_top.sv
tb/echo_rx_checker.sv
tb/echo_rx_tb.sv

// File: tb/echo_rx_stimulus.txt
# cfg: mac_dst mac_src ip_src ip_dst frame_id log_id, all hex
# frame: name id(hex) length corrupt skip gap (positions, 99 = none) outcome(report/none/drop)
# hold: 1 keeps report_ready low, 0 returns it to the random pattern
cfg 02a0c9112233 0050b6445566 c0a80a01 c0a80a02 4d2e 01f7
frame good_basic 1a2b 42 99 99 99 report
frame good_payload 3c4d 60 99 99 99 report
frame bad_mac_dst 0001 42 3 99 99 none
frame bad_ip_src 0002 46 27 99 99 none
frame bad_log_id 0003 42 39 99 99 none
frame cksum_ip 5e6f 42 24 99 99 report
frame cksum_icmp 7081 44 37 99 99 report
frame skip_byte 92a3 42 8 8 99 report
frame short_41 0004 41 99 99 99 none
frame gap_cut 0005 50 99 99 20 none
frame after_gap b4c5 42 99 99 99 report
frame wrong_type 0006 42 34 99 99 none
frame payload_diff d6e7 48 45 99 99 report
hold 1
frame burst_0 1001 42 99 99 99 report
frame burst_1 1002 43 99 99 99 report
frame burst_2 1003 42 99 99 99 report
frame burst_3 1004 50 99 99 99 report
frame burst_4 1005 42 99 99 99 drop
frame burst_5 1006 42 99 99 99 drop
hold 0
frame rand_0 2101 42 99 99 99 report
frame rand_1 2202 55 99 99 99 report
frame rand_2 2303 42 99 99 99 report
frame rand_3 2404 47 99 99 99 report
frame rand_4 2505 42 99 99 99 report
